/* cacheDramMonitor.f */
+incdir+rtl
rtl/monitorPkg.sv
rtl/txnEventIf.sv
rtl/readTracker.sv
rtl/writeTracker.sv
rtl/ddrCmdDecoder.sv
rtl/txnCounters.sv
rtl/cacheDramMonitor.sv
verification/tbClock.sv
verification/cacheDramMonitorTb.sv

/* rtl/cacheDramMonitor.sv */
`timescale 1ns/100ps
`default_nettype none

`include "monitor_settings.svh"

module cacheDramMonitor (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    // Cache link
    input  wire logic                   arValid,
    input  wire logic                   arReady,
    input  monitorPkg::axiAddr_t        arAddr,
    input  monitorPkg::axiId_t          arId,
    input  monitorPkg::axiUser_t        arUser,
    input  wire logic                   rValid,
    input  wire logic                   rReady,
    input  monitorPkg::axiData_t        rData,
    input  wire logic                   rLast,
    input  monitorPkg::axiId_t          rId,
    input  monitorPkg::axiUser_t        rUser,
    input  wire logic                   awValid,
    input  wire logic                   awReady,
    input  monitorPkg::axiAddr_t        awAddr,
    input  monitorPkg::axiId_t          awId,
    input  monitorPkg::axiUser_t        awUser,
    input  wire logic                   wValid,
    input  wire logic                   wReady,
    input  wire logic                   wLast,
    input  monitorPkg::axiId_t          wId,
    input  monitorPkg::axiUser_t        wUser,
    input  wire logic                   bValid,
    input  wire logic                   bReady,
    input  monitorPkg::axiId_t          bId,
    input  monitorPkg::axiUser_t        bUser,
    // DDR4 command pins
    input  wire logic [`NUM_RANK-1:0]   ch0CsN,
    input  wire logic                   ch0Cke,
    input  wire logic                   ch0ActN,
    input  monitorPkg::ddrPins_t        ch0Pins,
    input  monitorPkg::ddrBank_t        ch0Ba,
    input  monitorPkg::ddrBankGroup_t   ch0Bg,
    input  wire logic [`NUM_RANK-1:0]   ch1CsN,
    input  wire logic                   ch1Cke,
    input  wire logic                   ch1ActN,
    input  monitorPkg::ddrPins_t        ch1Pins,
    input  monitorPkg::ddrBank_t        ch1Ba,
    input  monitorPkg::ddrBankGroup_t   ch1Bg,
    // Cache events
    output logic                        rdReqValid,
    output monitorPkg::axiAddr_t        rdReqAddr,
    output monitorPkg::axiId_t          rdReqId,
    output monitorPkg::axiUser_t        rdReqUser,
    output logic                        rdRespValid,
    output monitorPkg::axiId_t          rdRespId,
    output monitorPkg::axiUser_t        rdRespUser,
    output monitorPkg::burstData_t      rdRespData,
    output logic                        wrReqValid,
    output monitorPkg::axiAddr_t        wrReqAddr,
    output monitorPkg::axiId_t          wrReqId,
    output monitorPkg::axiUser_t        wrReqUser,
    output logic                        wrAckValid,
    output monitorPkg::axiId_t          wrAckId,
    output monitorPkg::axiUser_t        wrAckUser,
    output monitorPkg::eventCount_t     rdReqCount,
    output monitorPkg::eventCount_t     rdRespCount,
    output monitorPkg::eventCount_t     wrReqCount,
    output monitorPkg::eventCount_t     wrAckCount,
    // DDR4 decode
    output logic                        ch0CmdValid,
    output monitorPkg::ddrCmd_e         ch0Cmd,
    output monitorPkg::rank_t           ch0Rank,
    output monitorPkg::ddrBank_t        ch0Bank,
    output monitorPkg::ddrBankGroup_t   ch0BankGroup,
    output logic                        ch1CmdValid,
    output monitorPkg::ddrCmd_e         ch1Cmd,
    output monitorPkg::rank_t           ch1Rank,
    output monitorPkg::ddrBank_t        ch1Bank,
    output monitorPkg::ddrBankGroup_t   ch1BankGroup
);

    txnEventIf reqRdIf ();
    txnEventIf respRdIf ();
    txnEventIf reqWrIf ();
    txnEventIf ackWrIf ();

    readTracker readTracker0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .arValid  (arValid),
        .arReady  (arReady),
        .arAddr   (arAddr),
        .arId     (arId),
        .arUser   (arUser),
        .rValid   (rValid),
        .rReady   (rReady),
        .rData    (rData),
        .rLast    (rLast),
        .rId      (rId),
        .rUser    (rUser),
        .reqRd    (reqRdIf.producer),
        .respRd   (respRdIf.producer),
        .respData (rdRespData)
    );

    writeTracker writeTracker0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .awValid (awValid),
        .awReady (awReady),
        .awAddr  (awAddr),
        .awId    (awId),
        .awUser  (awUser),
        .wValid  (wValid),
        .wReady  (wReady),
        .wLast   (wLast),
        .wId     (wId),
        .wUser   (wUser),
        .bValid  (bValid),
        .bReady  (bReady),
        .bId     (bId),
        .bUser   (bUser),
        .reqWr   (reqWrIf.producer),
        .ackWr   (ackWrIf.producer)
    );

    txnCounters txnCounters0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .reqRd       (reqRdIf.consumer),
        .respRd      (respRdIf.consumer),
        .reqWr       (reqWrIf.consumer),
        .ackWr       (ackWrIf.consumer),
        .rdReqCount  (rdReqCount),
        .rdRespCount (rdRespCount),
        .wrReqCount  (wrReqCount),
        .wrAckCount  (wrAckCount)
    );

    ddrCmdDecoder ch0Decoder (
        .csN          (ch0CsN),
        .cke          (ch0Cke),
        .actN         (ch0ActN),
        .pins         (ch0Pins),
        .bank         (ch0Ba),
        .bankGroup    (ch0Bg),
        .cmdValid     (ch0CmdValid),
        .cmd          (ch0Cmd),
        .cmdRank      (ch0Rank),
        .cmdBank      (ch0Bank),
        .cmdBankGroup (ch0BankGroup)
    );

    ddrCmdDecoder ch1Decoder (
        .csN          (ch1CsN),
        .cke          (ch1Cke),
        .actN         (ch1ActN),
        .pins         (ch1Pins),
        .bank         (ch1Ba),
        .bankGroup    (ch1Bg),
        .cmdValid     (ch1CmdValid),
        .cmd          (ch1Cmd),
        .cmdRank      (ch1Rank),
        .cmdBank      (ch1Bank),
        .cmdBankGroup (ch1BankGroup)
    );

    // Events out to plain ports
    assign rdReqValid  = reqRdIf.valid;
    assign rdReqAddr   = reqRdIf.addr;
    assign rdReqId     = reqRdIf.id;
    assign rdReqUser   = reqRdIf.user;

    assign rdRespValid = respRdIf.valid;
    assign rdRespId    = respRdIf.id;
    assign rdRespUser  = respRdIf.user;

    assign wrReqValid  = reqWrIf.valid;
    assign wrReqAddr   = reqWrIf.addr;
    assign wrReqId     = reqWrIf.id;
    assign wrReqUser   = reqWrIf.user;

    assign wrAckValid  = ackWrIf.valid;
    assign wrAckId     = ackWrIf.id;
    assign wrAckUser   = ackWrIf.user;

endmodule

`default_nettype wire

/* rtl/ddrCmdDecoder.sv */
`timescale 1ns/100ps
`default_nettype none

`include "monitor_settings.svh"

module ddrCmdDecoder (
    input  wire logic [`NUM_RANK-1:0]  csN,
    input  wire logic                  cke,
    input  wire logic                  actN,
    input  monitorPkg::ddrPins_t       pins,
    input  monitorPkg::ddrBank_t       bank,
    input  monitorPkg::ddrBankGroup_t  bankGroup,
    output logic                       cmdValid,
    output monitorPkg::ddrCmd_e        cmd,
    output monitorPkg::rank_t          cmdRank,
    output monitorPkg::ddrBank_t       cmdBank,
    output monitorPkg::ddrBankGroup_t  cmdBankGroup
);
    import monitorPkg::*;

    // RAS, CAS and WE share address pins outside activate
    localparam int rasBit = 16;
    localparam int casBit = 15;
    localparam int weBit  = 14;
    localparam int apBit  = 10;

    logic rankSel;

    assign rankSel = ~&csN;

    always_comb begin
        cmdRank = '0;
        for (int i = `NUM_RANK - 1; i >= 0; i--) begin
            if (!csN[i]) begin
                cmdRank = rank_t'(i);
            end
        end
    end

    always_comb begin
        cmd = CMD_IDLE;
        if (rankSel && cke) begin
            if (!actN) begin
                cmd = CMD_ACTIVATE;
            end else begin
                case ({pins[rasBit], pins[casBit], pins[weBit]})
                    3'b101:  cmd = pins[apBit] ? CMD_READ_AP : CMD_READ;
                    3'b100:  cmd = pins[apBit] ? CMD_WRITE_AP : CMD_WRITE;
                    3'b001:  cmd = CMD_REFRESH;
                    3'b010:  cmd = CMD_PRECHARGE;
                    default: cmd = CMD_IDLE;
                endcase
            end
        end
    end

    assign cmdValid     = (cmd != CMD_IDLE);
    assign cmdBank      = bank;
    assign cmdBankGroup = bankGroup;

    // Only one rank addressed per command slot
    always_comb begin
        if (cke) begin
            oneRank: assert ($countones(~csN) <= 1);
        end
    end

endmodule

`default_nettype wire

/* rtl/monitorPkg.sv */
`default_nettype none

`include "monitor_settings.svh"

package monitorPkg;

    // Cache link fields
    typedef logic [`ID_WIDTH-1:0]   axiId_t;
    typedef logic [`USER_WIDTH-1:0] axiUser_t;
    typedef logic [`ADDR_WIDTH-1:0] axiAddr_t;
    typedef logic [`DATA_WIDTH-1:0] axiData_t;

    // Beat 0 in the lowest bits
    typedef logic [`DATA_WIDTH*`BURST_LEN-1:0] burstData_t;
    typedef logic [$clog2(`BURST_LEN)-1:0]    beatIdx_t;

    // DDR4 command side
    typedef logic [$clog2(`NUM_RANK)-1:0] rank_t;
    typedef logic [1:0]                   ddrBank_t;
    typedef logic [1:0]                   ddrBankGroup_t;
    typedef logic [`DDR_ADDR_WIDTH-1:0]   ddrPins_t;

    typedef logic [`COUNT_WIDTH-1:0] eventCount_t;

    typedef enum logic [2:0] {
        CMD_IDLE,
        CMD_ACTIVATE,
        CMD_READ,
        CMD_READ_AP,
        CMD_WRITE,
        CMD_WRITE_AP,
        CMD_REFRESH,
        CMD_PRECHARGE
    } ddrCmd_e;

endpackage

`default_nettype wire

/* rtl/monitor_settings.svh */
`ifndef MONITOR_SETTINGS_SVH
`define MONITOR_SETTINGS_SVH

// AXI link between cache and memory controller
`define ID_WIDTH        2
`define USER_WIDTH      2
`define ADDR_WIDTH      32
`define DATA_WIDTH      32
`define BURST_LEN       4

// DDR4 command bus
`define NUM_RANK        2
`define DDR_ADDR_WIDTH  17

// Event counters
`define COUNT_WIDTH     16

`endif

/* rtl/readTracker.sv */
`timescale 1ns/100ps
`default_nettype none

`include "monitor_settings.svh"

module readTracker (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  arValid,
    input  wire logic                  arReady,
    input  monitorPkg::axiAddr_t       arAddr,
    input  monitorPkg::axiId_t         arId,
    input  monitorPkg::axiUser_t       arUser,
    input  wire logic                  rValid,
    input  wire logic                  rReady,
    input  monitorPkg::axiData_t       rData,
    input  wire logic                  rLast,
    input  monitorPkg::axiId_t         rId,
    input  monitorPkg::axiUser_t       rUser,
    txnEventIf.producer                reqRd,
    txnEventIf.producer                respRd,
    output monitorPkg::burstData_t     respData
);
    import monitorPkg::*;

    logic       rBeat;
    beatIdx_t   beatIdx;
    burstData_t beatBuf;

    assign rBeat = rValid && rReady;

    assign reqRd.valid = arValid && arReady;
    assign reqRd.id    = arId;
    assign reqRd.user  = arUser;
    assign reqRd.addr  = arAddr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beatIdx <= '0;
        end else if (rBeat) begin
            if (beatIdx == beatIdx_t'(`BURST_LEN - 1)) begin
                beatIdx <= '0;
            end else begin
                beatIdx <= beatIdx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rBeat) begin
            beatBuf[beatIdx*`DATA_WIDTH +: `DATA_WIDTH] <= rData;
        end
    end

    // Current beat merged over the earlier ones
    always_comb begin
        respData = beatBuf;
        respData[beatIdx*`DATA_WIDTH +: `DATA_WIDTH] = rData;
    end

    assign respRd.valid = rBeat && rLast;
    assign respRd.id    = rId;
    assign respRd.user  = rUser;
    assign respRd.addr  = '0;

    // Bursts are always BURST_LEN beats long
    burstLength: assert property (@(posedge clk) disable iff (!rst_n)
        rBeat |-> (rLast == (beatIdx == beatIdx_t'(`BURST_LEN - 1))));

endmodule

`default_nettype wire

/* rtl/txnCounters.sv */
`timescale 1ns/100ps
`default_nettype none

module txnCounters (
    input  wire logic                clk,
    input  wire logic                rst_n,
    txnEventIf.consumer              reqRd,
    txnEventIf.consumer              respRd,
    txnEventIf.consumer              reqWr,
    txnEventIf.consumer              ackWr,
    output monitorPkg::eventCount_t  rdReqCount,
    output monitorPkg::eventCount_t  rdRespCount,
    output monitorPkg::eventCount_t  wrReqCount,
    output monitorPkg::eventCount_t  wrAckCount
);

    // Counters wrap at full scale
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdReqCount  <= '0;
            rdRespCount <= '0;
            wrReqCount  <= '0;
            wrAckCount  <= '0;
        end else begin
            if (reqRd.valid) begin
                rdReqCount <= rdReqCount + 1'b1;
            end
            if (respRd.valid) begin
                rdRespCount <= rdRespCount + 1'b1;
            end
            if (reqWr.valid) begin
                wrReqCount <= wrReqCount + 1'b1;
            end
            if (ackWr.valid) begin
                wrAckCount <= wrAckCount + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/txnEventIf.sv */
`timescale 1ns/100ps
`default_nettype none

// One observed cache transaction event
interface txnEventIf;
    import monitorPkg::*;

    logic     valid;
    axiId_t   id;
    axiUser_t user;
    axiAddr_t addr;

    modport producer (output valid, id, user, addr);
    modport consumer (input valid, id, user, addr);

endinterface

`default_nettype wire

/* rtl/writeTracker.sv */
`timescale 1ns/100ps
`default_nettype none

module writeTracker (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              awValid,
    input  wire logic              awReady,
    input  monitorPkg::axiAddr_t   awAddr,
    input  monitorPkg::axiId_t     awId,
    input  monitorPkg::axiUser_t   awUser,
    input  wire logic              wValid,
    input  wire logic              wReady,
    input  wire logic              wLast,
    input  monitorPkg::axiId_t     wId,
    input  monitorPkg::axiUser_t   wUser,
    input  wire logic              bValid,
    input  wire logic              bReady,
    input  monitorPkg::axiId_t     bId,
    input  monitorPkg::axiUser_t   bUser,
    txnEventIf.producer            reqWr,
    txnEventIf.producer            ackWr
);
    import monitorPkg::*;

    localparam int numEntries = 4;
    typedef logic [$clog2(numEntries)-1:0] entryIdx_t;

    logic [numEntries-1:0] entryFree;
    axiAddr_t              entryAddr [numEntries];
    axiId_t                entryId   [numEntries];
    axiUser_t              entryUser [numEntries];

    logic      awFire;
    logic      wLastFire;
    logic      combined;
    logic      tableFull;
    logic      matchHit;
    entryIdx_t freeIdx;
    entryIdx_t matchIdx;

    assign awFire    = awValid && awReady;
    assign wLastFire = wValid && wReady && wLast;
    assign combined  = awFire && wLastFire && (awId == wId) && (awUser == wUser);
    assign tableFull = ~|entryFree;

    // Lowest free slot
    always_comb begin
        freeIdx = '0;
        for (int i = numEntries - 1; i >= 0; i--) begin
            if (entryFree[i]) begin
                freeIdx = entryIdx_t'(i);
            end
        end
    end

    // Occupied slot with the same ID and user as the data beat
    always_comb begin
        matchHit = 1'b0;
        matchIdx = '0;
        for (int i = 0; i < numEntries; i++) begin
            if (!entryFree[i] && entryId[i] == wId && entryUser[i] == wUser) begin
                matchHit = 1'b1;
                matchIdx = entryIdx_t'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entryFree <= '1;
        end else begin
            if (awFire && !combined) begin
                entryFree[freeIdx] <= 1'b0;
            end
            if (wLastFire && !combined && matchHit) begin
                entryFree[matchIdx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (awFire && !combined) begin
            entryAddr[freeIdx] <= awAddr;
            entryId[freeIdx]   <= awId;
            entryUser[freeIdx] <= awUser;
        end
    end

    assign reqWr.valid = wLastFire;
    assign reqWr.id    = wId;
    assign reqWr.user  = wUser;
    assign reqWr.addr  = combined ? awAddr : entryAddr[matchIdx];

    assign ackWr.valid = bValid && bReady;
    assign ackWr.id    = bId;
    assign ackWr.user  = bUser;
    assign ackWr.addr  = '0;

    noOverflow: assert property (@(posedge clk) disable iff (!rst_n)
        (awFire && !combined) |-> !tableFull);

    // Data never closes a write whose address was not seen
    lastHasAddr: assert property (@(posedge clk) disable iff (!rst_n)
        (wLastFire && !combined) |-> matchHit);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the cacheDramMonitor testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f cacheDramMonitor.f \
    --top-module cacheDramMonitorTb -o simv > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "Simulation exited with an error, see sim.log"
    exit 1
fi

if grep -qx "TEST PASS" sim.log; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed, see sim.log"
exit 1

/* verification/cacheDramMonitorTb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "monitor_settings.svh"

module cacheDramMonitorTb;
    import monitorPkg::*;

    localparam int numCycles  = 3000;
    localparam int watchdogNs = (numCycles + 16 + 200) * 100;
    localparam int maxPending = 4;

    logic clk;
    logic rst_n;

    logic arValid, arReady, rValid, rReady, rLast;
    logic awValid, awReady, wValid, wReady, wLast, bValid, bReady;
    axiAddr_t arAddr, awAddr;
    axiId_t arId, rId, awId, wId, bId;
    axiUser_t arUser, rUser, awUser, wUser, bUser;
    axiData_t rData;
    logic [`NUM_RANK-1:0] ch0CsN, ch1CsN;
    logic ch0Cke, ch0ActN, ch1Cke, ch1ActN;
    ddrPins_t ch0Pins, ch1Pins;
    ddrBank_t ch0Ba, ch1Ba;
    ddrBankGroup_t ch0Bg, ch1Bg;

    logic rdReqValid, rdRespValid, wrReqValid, wrAckValid;
    axiAddr_t rdReqAddr, wrReqAddr;
    axiId_t rdReqId, rdRespId, wrReqId, wrAckId;
    axiUser_t rdReqUser, rdRespUser, wrReqUser, wrAckUser;
    burstData_t rdRespData;
    eventCount_t rdReqCount, rdRespCount, wrReqCount, wrAckCount;
    logic ch0CmdValid, ch1CmdValid;
    ddrCmd_e ch0Cmd, ch1Cmd;
    rank_t ch0Rank, ch1Rank;
    ddrBank_t ch0Bank, ch1Bank;
    ddrBankGroup_t ch0BankGroup, ch1BankGroup;

    // Reference model state
    axiAddr_t pendAddr[$];
    axiId_t pendId[$];
    axiUser_t pendUser[$];
    axiData_t burstBuf [`BURST_LEN];
    int beatCount;
    eventCount_t expRdReq, expRdResp, expWrReq, expWrAck;

    // Handshakes seen in the current cycle
    logic rdFire, rBeatFire, awFire, wLastFire, combinedWr, bFire;
    int matchPos;

    integer seed;
    int errorCount;
    int cycleCount;

    tbClock tbClock0 (.clk(clk), .rst_n(rst_n));

    cacheDramMonitor dut0 (.*, .ch0Ba(ch0Ba), .ch0Bg(ch0Bg), .ch1Ba(ch1Ba), .ch1Bg(ch1Bg));

    function automatic logic [31:0] randBits();
        return $random(seed);
    endfunction

    function automatic logic randBit();
        logic [31:0] r;
        r = $random(seed);
        return r[0];
    endfunction

    task automatic reportMismatch(input string sigName, input logic [127:0] got,
                                  input logic [127:0] exp);
        $display("MISMATCH time=%0t %s got=%0h expected=%0h", $time, sigName, got, exp);
        errorCount++;
    endtask

    // DDR4 command truth table
    function automatic ddrCmd_e modelCmd(input logic [`NUM_RANK-1:0] csN, input logic cke,
                                         input logic actN, input ddrPins_t pins);
        logic ras;
        logic cas;
        logic we;
        ras = pins[16];
        cas = pins[15];
        we  = pins[14];
        if (cke !== 1'b1 || &csN) return CMD_IDLE;
        if (!actN) return CMD_ACTIVATE;
        if (ras && !cas && we) return pins[10] ? CMD_READ_AP : CMD_READ;
        if (ras && !cas && !we) return pins[10] ? CMD_WRITE_AP : CMD_WRITE;
        if (!ras && !cas && we) return CMD_REFRESH;
        if (!ras && cas && !we) return CMD_PRECHARGE;
        return CMD_IDLE;
    endfunction

    function automatic rank_t modelRank(input logic [`NUM_RANK-1:0] csN);
        rank_t rank;
        logic found;
        rank = '0;
        found = 1'b0;
        for (int i = 0; i < `NUM_RANK; i++) begin
            if (!found && !csN[i]) begin
                rank = rank_t'(i);
                found = 1'b1;
            end
        end
        return rank;
    endfunction

    task automatic checkChannel(input string chName, input logic [`NUM_RANK-1:0] csN,
                                input logic cke, input logic actN, input ddrPins_t pins,
                                input ddrBank_t ba, input ddrBankGroup_t bg,
                                input logic gotValid, input ddrCmd_e gotCmd,
                                input rank_t gotRank, input ddrBank_t gotBank,
                                input ddrBankGroup_t gotBg);
        ddrCmd_e expCmd;
        expCmd = modelCmd(csN, cke, actN, pins);
        if (gotCmd !== expCmd)
            reportMismatch({chName, "Cmd"}, 128'(gotCmd), 128'(expCmd));
        if (gotValid !== (expCmd != CMD_IDLE))
            reportMismatch({chName, "CmdValid"}, 128'(gotValid), 128'(expCmd != CMD_IDLE));
        if (gotRank !== modelRank(csN))
            reportMismatch({chName, "Rank"}, 128'(gotRank), 128'(modelRank(csN)));
        if (gotBank !== ba)
            reportMismatch({chName, "Bank"}, 128'(gotBank), 128'(ba));
        if (gotBg !== bg)
            reportMismatch({chName, "BankGroup"}, 128'(gotBg), 128'(bg));
    endtask

    task automatic clearInputs();
        {arValid, arReady, rValid, rReady, rLast} = '0;
        {awValid, awReady, wValid, wReady, wLast, bValid, bReady} = '0;
        {arAddr, awAddr, rData} = '0;
        {arId, rId, awId, wId, bId, arUser, rUser, awUser, wUser, bUser} = '0;
        {ch0CsN, ch1CsN} = '1;
        {ch0Cke, ch1Cke} = '0;
        {ch0ActN, ch1ActN} = '1;
        {ch0Pins, ch1Pins, ch0Ba, ch1Ba, ch0Bg, ch1Bg} = '0;
    endtask

    // One chip select low at most, never two
    function automatic logic [`NUM_RANK-1:0] randCsN();
        logic [31:0] r;
        r = randBits() % 32'd3;
        if (r == 32'd0) return 2'b11;
        if (r == 32'd1) return 2'b10;
        return 2'b01;
    endfunction

    task automatic driveInputs();
        logic pairBusy;
        logic [31:0] r;
        int pick;
        arValid = randBit();
        arReady = randBit();
        arAddr  = randBits();
        arId    = axiId_t'(randBits());
        arUser  = axiUser_t'(randBits());
        rValid  = randBit();
        rReady  = randBit();
        rData   = randBits();
        rLast   = (beatCount == `BURST_LEN - 1);
        rId     = axiId_t'(randBits());
        rUser   = axiUser_t'(randBits());

        awValid = randBit();
        awAddr  = randBits();
        awId    = axiId_t'(randBits());
        awUser  = axiUser_t'(randBits());
        pairBusy = 1'b0;
        foreach (pendId[i]) begin
            if (pendId[i] == awId && pendUser[i] == awUser) pairBusy = 1'b1;
        end
        awReady = (pendId.size() < maxPending && !pairBusy) ? randBit() : 1'b0;

        r = randBits() % 32'd4;
        if (awValid && awReady && r == 32'd0) begin
            // Address and last data beat in the same cycle
            {wValid, wReady, wLast} = 3'b111;
            wId   = awId;
            wUser = awUser;
        end else if (pendId.size() > 0 && (r == 32'd1 || r == 32'd2)) begin
            pick   = int'(randBits() % 32'(pendId.size()));
            wValid = randBit();
            wReady = randBit();
            wLast  = 1'b1;
            wId    = pendId[pick];
            wUser  = pendUser[pick];
        end else begin
            wValid = randBit();
            wReady = randBit();
            wLast  = 1'b0;
            wId    = axiId_t'(randBits());
            wUser  = axiUser_t'(randBits());
        end

        bValid = randBit();
        bReady = randBit();
        bId    = axiId_t'(randBits());
        bUser  = axiUser_t'(randBits());

        ch0CsN  = randCsN();
        ch0Cke  = (randBits() % 32'd8) != 32'd0;
        ch0ActN = randBit();
        ch0Pins = ddrPins_t'(randBits());
        ch0Ba   = ddrBank_t'(randBits());
        ch0Bg   = ddrBankGroup_t'(randBits());
        ch1CsN  = randCsN();
        ch1Cke  = (randBits() % 32'd8) != 32'd0;
        ch1ActN = randBit();
        ch1Pins = ddrPins_t'(randBits());
        ch1Ba   = ddrBank_t'(randBits());
        ch1Bg   = ddrBankGroup_t'(randBits());
    endtask

    task automatic checkOutputs();
        burstData_t expData;
        axiAddr_t expAddr;
        // Counts hold the events up to the previous cycle
        if (rdReqCount !== expRdReq)
            reportMismatch("rdReqCount", 128'(rdReqCount), 128'(expRdReq));
        if (rdRespCount !== expRdResp)
            reportMismatch("rdRespCount", 128'(rdRespCount), 128'(expRdResp));
        if (wrReqCount !== expWrReq)
            reportMismatch("wrReqCount", 128'(wrReqCount), 128'(expWrReq));
        if (wrAckCount !== expWrAck)
            reportMismatch("wrAckCount", 128'(wrAckCount), 128'(expWrAck));

        rdFire = arValid && arReady;
        if (rdReqValid !== rdFire)
            reportMismatch("rdReqValid", 128'(rdReqValid), 128'(rdFire));
        if (rdFire && rdReqAddr !== arAddr)
            reportMismatch("rdReqAddr", 128'(rdReqAddr), 128'(arAddr));
        if (rdFire && {rdReqId, rdReqUser} !== {arId, arUser})
            reportMismatch("rdReqId/User", 128'({rdReqId, rdReqUser}), 128'({arId, arUser}));

        rBeatFire = rValid && rReady;
        if (rdRespValid !== (rBeatFire && rLast))
            reportMismatch("rdRespValid", 128'(rdRespValid), 128'(rBeatFire && rLast));
        if (rBeatFire && rLast) begin
            for (int b = 0; b < `BURST_LEN; b++) begin
                expData[b*`DATA_WIDTH +: `DATA_WIDTH] = (b == beatCount) ? rData : burstBuf[b];
            end
            if (rdRespData !== expData)
                reportMismatch("rdRespData", 128'(rdRespData), 128'(expData));
            if ({rdRespId, rdRespUser} !== {rId, rUser})
                reportMismatch("rdRespId/User", 128'({rdRespId, rdRespUser}), 128'({rId, rUser}));
        end

        awFire = awValid && awReady;
        wLastFire = wValid && wReady && wLast;
        combinedWr = awFire && wLastFire && awId == wId && awUser == wUser;
        matchPos = -1;
        foreach (pendId[i]) begin
            if (pendId[i] == wId && pendUser[i] == wUser) matchPos = i;
        end
        if (wrReqValid !== wLastFire)
            reportMismatch("wrReqValid", 128'(wrReqValid), 128'(wLastFire));
        if (wLastFire && !combinedWr && matchPos < 0) begin
            $display("ERROR time=%0t last write beat has no pending address in the model", $time);
            errorCount++;
        end else if (wLastFire) begin
            expAddr = combinedWr ? awAddr : pendAddr[matchPos];
            if (wrReqAddr !== expAddr)
                reportMismatch("wrReqAddr", 128'(wrReqAddr), 128'(expAddr));
            if ({wrReqId, wrReqUser} !== {wId, wUser})
                reportMismatch("wrReqId/User", 128'({wrReqId, wrReqUser}), 128'({wId, wUser}));
        end

        bFire = bValid && bReady;
        if (wrAckValid !== bFire)
            reportMismatch("wrAckValid", 128'(wrAckValid), 128'(bFire));
        if (bFire && {wrAckId, wrAckUser} !== {bId, bUser})
            reportMismatch("wrAckId/User", 128'({wrAckId, wrAckUser}), 128'({bId, bUser}));

        checkChannel("ch0", ch0CsN, ch0Cke, ch0ActN, ch0Pins, ch0Ba, ch0Bg,
                     ch0CmdValid, ch0Cmd, ch0Rank, ch0Bank, ch0BankGroup);
        checkChannel("ch1", ch1CsN, ch1Cke, ch1ActN, ch1Pins, ch1Ba, ch1Bg,
                     ch1CmdValid, ch1Cmd, ch1Rank, ch1Bank, ch1BankGroup);
    endtask

    task automatic updateModel();
        if (rdFire) expRdReq++;
        if (rBeatFire && rLast) expRdResp++;
        if (wLastFire) expWrReq++;
        if (bFire) expWrAck++;
        if (rBeatFire) begin
            burstBuf[beatCount] = rData;
            beatCount = (beatCount + 1) % `BURST_LEN;
        end
        if (wLastFire && !combinedWr && matchPos >= 0) begin
            pendAddr.delete(matchPos);
            pendId.delete(matchPos);
            pendUser.delete(matchPos);
        end
        if (awFire && !combinedWr) begin
            pendAddr.push_back(awAddr);
            pendId.push_back(awId);
            pendUser.push_back(awUser);
        end
    endtask

    initial begin
        seed = 32'h6bddf35b;
        errorCount = 0;
        cycleCount = 0;
        beatCount = 0;
        {expRdReq, expRdResp, expWrReq, expWrAck} = '0;
        clearInputs();
        @(posedge rst_n);
        repeat (numCycles) begin
            @(posedge clk);
            #10;
            driveInputs();
            #50;
            checkOutputs();
            updateModel();
            cycleCount++;
        end
        $display("Cycles run: %0d, errors: %0d", cycleCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #watchdogNs;
        $display("ERROR watchdog expired after %0d ns before the test completed", watchdogNs);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/tbClock.sv */
`timescale 1ns/100ps
`default_nettype none

module tbClock (
    output logic clk,
    output logic rst_n
);
    localparam int halfPeriod  = 50;
    localparam int resetCycles = 16;

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    // Release just after a rising edge, like the other inputs
    initial begin
        rst_n = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #10;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire
